// File: sccb_pkg.sv
// **********************************************************************
// bus side: one register transaction toward the I2C/SCCB master
// **********************************************************************
package sccb_pkg;

    // one register command, 25 bits
    typedef struct packed {
        logic [15:0] reg_addr;   // sensor register address
        logic [7:0]  reg_data;   // value to write, don't care on reads
        logic        rd;         // 1 = read, 0 = write
    } sccb_cmd_t;

    // sequencer states
    typedef enum logic [1:0] {
        WAIT_POWER = 2'd0,       // settle time still running
        ISSUE      = 2'd1,       // exec pulse out this cycle
        BUSY       = 2'd2,       // waiting on master's done
        FINISHED   = 2'd3        // whole table sent
    } seq_state_t;

endpackage

// File: ov5640_pkg.sv
// **********************************************************************
// sensor side: window geometry, table size, key registers
// **********************************************************************
package ov5640_pkg;

    // output window geometry, 52 bits
    typedef struct packed {
        logic [12:0] h_pixel;    // output width
        logic [12:0] v_pixel;    // output height
        logic [12:0] total_h;    // total line length (HTS)
        logic [12:0] total_v;    // total frame length (VTS)
    } cmos_window_t;

    localparam int TABLE_LEN    = 45;   // entries in the register table
    localparam int READ_ENTRIES = 2;    // leading ID reads
    localparam int IDX_W        = 6;    // enough for TABLE_LEN

    // chip id
    localparam logic [15:0] REG_CHIP_ID_H = 16'h300a;
    localparam logic [15:0] REG_CHIP_ID_L = 16'h300b;

    // system control, bit 7 is soft reset
    localparam logic [15:0] REG_SYS_CTRL0 = 16'h3008;

    // output format
    localparam logic [15:0] REG_FORMAT_CTRL = 16'h4300;

    // dvp output size
    localparam logic [15:0] REG_OUT_HSIZE_H = 16'h3808;
    localparam logic [15:0] REG_OUT_HSIZE_L = 16'h3809;
    localparam logic [15:0] REG_OUT_VSIZE_H = 16'h380a;
    localparam logic [15:0] REG_OUT_VSIZE_L = 16'h380b;

    // total line / frame size
    localparam logic [15:0] REG_TOTAL_HS_H = 16'h380c;
    localparam logic [15:0] REG_TOTAL_HS_L = 16'h380d;
    localparam logic [15:0] REG_TOTAL_VS_H = 16'h380e;
    localparam logic [15:0] REG_TOTAL_VS_L = 16'h380f;

    // colour bar / test pattern
    localparam logic [15:0] REG_PRE_ISP_TEST = 16'h503d;

endpackage

// File: powerup_delay.sv
`timescale 1ns/1ps

module powerup_delay #(
    parameter int WAIT_CYCLES = 5000    // 20 ms at 250 kHz
) (
    input  logic clk,
    input  logic rst_n,
    output logic power_ok
);

    localparam int CNT_W = $clog2(WAIT_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    // saturating settle counter, stops at WAIT_CYCLES
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt != CNT_W'(WAIT_CYCLES)) begin
            cnt <= cnt + 1'b1;
        end
    end

    // single pulse, in the cycle the count lands on WAIT_CYCLES
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            power_ok <= 1'b0;
        end else begin
            power_ok <= (cnt == CNT_W'(WAIT_CYCLES - 1));   // count held after, never repeats
        end
    end

endmodule

// File: cfg_table.sv
`timescale 1ns/1ps

module cfg_table
    import sccb_pkg::*;
    import ov5640_pkg::*;
(
    input  logic [IDX_W-1:0] entry_idx,
    input  cmos_window_t     window,
    output sccb_cmd_t        entry_cmd
);

    logic [15:0] addr;
    logic [7:0]  data;
    logic        past_end;

    // **********************************************************************
    // register table, index -> address / value
    // **********************************************************************
    always_comb begin
        past_end = 1'b0;
        case (entry_idx)
            // id read first
            6'd0  : begin addr = REG_CHIP_ID_H;  data = 8'h00; end
            6'd1  : begin addr = REG_CHIP_ID_L;  data = 8'h00; end
            // soft reset, then back to normal
            6'd2  : begin addr = REG_SYS_CTRL0;  data = 8'h82; end
            6'd3  : begin addr = REG_SYS_CTRL0;  data = 8'h02; end
            6'd4  : begin addr = 16'h3103;       data = 8'h02; end  // clock from pll
            // pad control, all outputs
            6'd5  : begin addr = 16'h3017;       data = 8'hff; end
            6'd6  : begin addr = 16'h3018;       data = 8'hff; end
            // pll and clocks
            6'd7  : begin addr = 16'h3037;       data = 8'h13; end
            6'd8  : begin addr = 16'h3108;       data = 8'h01; end  // root divider
            6'd9  : begin addr = 16'h3035;       data = 8'h11; end  // sys clk div
            6'd10 : begin addr = 16'h3036;       data = 8'h3c; end  // pll multiplier
            6'd11 : begin addr = 16'h3000;       data = 8'h00; end  // block resets off
            6'd12 : begin addr = 16'h3004;       data = 8'hff; end  // clock enables
            // rgb565 and isp
            6'd13 : begin addr = REG_FORMAT_CTRL; data = 8'h61; end
            6'd14 : begin addr = 16'h501f;       data = 8'h01; end  // isp rgb
            6'd15 : begin addr = 16'h5000;       data = 8'ha7; end
            6'd16 : begin addr = 16'h5001;       data = 8'ha3; end
            // **********************************************************************
            // timing / window group
            // **********************************************************************
            6'd17 : begin addr = 16'h3820;       data = 8'h46; end
            6'd18 : begin addr = 16'h3821;       data = 8'h01; end
            6'd19 : begin addr = 16'h3814;       data = 8'h31; end
            6'd20 : begin addr = 16'h3815;       data = 8'h31; end
            6'd21 : begin addr = 16'h3800;       data = 8'h00; end
            6'd22 : begin addr = 16'h3801;       data = 8'h00; end
            6'd23 : begin addr = 16'h3802;       data = 8'h00; end
            6'd24 : begin addr = 16'h3803;       data = 8'h04; end
            6'd25 : begin addr = 16'h3804;       data = 8'h0a; end
            6'd26 : begin addr = 16'h3805;       data = 8'h3f; end
            6'd27 : begin addr = 16'h3806;       data = 8'h07; end
            6'd28 : begin addr = 16'h3807;       data = 8'h9b; end
            // geometry-derived, upper part zero padded
            6'd29 : begin
                addr = REG_OUT_HSIZE_H;
                data = {4'd0, window.h_pixel[11:8]};
            end
            6'd30 : begin addr = REG_OUT_HSIZE_L; data = window.h_pixel[7:0]; end
            6'd31 : begin
                addr = REG_OUT_VSIZE_H;
                data = {5'd0, window.v_pixel[10:8]};
            end
            6'd32 : begin addr = REG_OUT_VSIZE_L; data = window.v_pixel[7:0]; end
            6'd33 : begin
                addr = REG_TOTAL_HS_H;
                data = {3'd0, window.total_h[12:8]};
            end
            6'd34 : begin addr = REG_TOTAL_HS_L;  data = window.total_h[7:0]; end
            6'd35 : begin
                addr = REG_TOTAL_VS_H;
                data = {3'd0, window.total_v[12:8]};
            end
            6'd36 : begin addr = REG_TOTAL_VS_L;  data = window.total_v[7:0]; end
            6'd37 : begin addr = 16'h3810;       data = 8'h00; end  // h offset hi
            6'd38 : begin addr = 16'h3811;       data = 8'h10; end  // h offset lo
            6'd39 : begin addr = 16'h3813;       data = 8'h06; end  // v offset lo
            // exposure limits, 60 then 50 hz
            6'd40 : begin addr = 16'h3a02;       data = 8'h17; end
            6'd41 : begin addr = 16'h3a03;       data = 8'h10; end
            6'd42 : begin addr = 16'h3a14;       data = 8'h17; end
            6'd43 : begin addr = 16'h3a15;       data = 8'h10; end
            // normal image, 8'h80 gives colour bars
            6'd44 : begin addr = REG_PRE_ISP_TEST; data = 8'h00; end
            default : begin
                // harmless id read past the end
                addr     = REG_CHIP_ID_H;
                data     = 8'h00;
                past_end = 1'b1;
            end
        endcase
    end

    assign entry_cmd.reg_addr = addr;
    assign entry_cmd.reg_data = data;
    assign entry_cmd.rd       = (entry_idx < IDX_W'(READ_ENTRIES)) || past_end;

endmodule

// File: cfg_sequencer.sv
`timescale 1ns/1ps

module cfg_sequencer
    import sccb_pkg::*;
    import ov5640_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             power_ok,
    input  logic             i2c_done,
    input  sccb_cmd_t        entry_cmd,
    output logic [IDX_W-1:0] entry_idx,
    output logic             i2c_exec,
    output sccb_cmd_t        i2c_cmd,
    output logic             init_done
);

    seq_state_t       state;
    logic [IDX_W-1:0] idx;     // next entry to fetch from the table

    // **********************************************************************
    // control FSM
    // **********************************************************************
    // idx steps forward as each command goes out, so while BUSY the table
    // already presents the following entry and it can be latched on done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= WAIT_POWER;
            idx     <= '0;
            i2c_cmd <= '0;
        end else begin
            case (state)
                WAIT_POWER: begin
                    if (power_ok) begin
                        state   <= ISSUE;
                        i2c_cmd <= entry_cmd;    // entry 0
                    end
                end
                ISSUE: begin
                    state <= BUSY;               // exec is a single cycle
                    idx   <= idx + 1'b1;
                end
                BUSY: begin
                    if (i2c_done) begin
                        if (idx == IDX_W'(TABLE_LEN)) begin
                            state <= FINISHED;   // last one acknowledged
                        end else begin
                            state   <= ISSUE;
                            i2c_cmd <= entry_cmd;
                        end
                    end
                end
                FINISHED: begin
                    state <= FINISHED;           // idle until reset
                end
                default: begin
                    state <= WAIT_POWER;
                end
            endcase
        end
    end

    assign entry_idx = idx;
    assign i2c_exec  = (state == ISSUE);
    assign init_done = (state == FINISHED);

    // **********************************************************************
    // handshake checks
    // **********************************************************************

    // one command outstanding at a time, next exec only after done
    a_no_exec_in_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == BUSY && !i2c_done) |=> !i2c_exec
    ) else $error("exec raised while a command is outstanding");

    // a done with nothing outstanding is a master protocol error
    a_done_only_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        i2c_done |-> (state == BUSY)
    ) else $error("i2c_done with no command outstanding");

    // command held steady while the master works on it
    a_cmd_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == BUSY && !i2c_done) |=> $stable(i2c_cmd)
    ) else $error("i2c_cmd changed before done");

    a_done_sticky : assert property (
        @(posedge clk) disable iff (!rst_n)
        init_done |=> init_done
    ) else $error("init_done fell");

endmodule

// File: ov5640_cfg_top.sv
`timescale 1ns/1ps

module ov5640_cfg_top
    import sccb_pkg::*;
    import ov5640_pkg::*;
#(
    parameter int WAIT_CYCLES = 5000    // 20 ms settle at 250 kHz
) (
    input  logic         clk,
    input  logic         rst_n,
    input  cmos_window_t window,      // static geometry
    input  logic         i2c_done,
    output logic         i2c_exec,
    output sccb_cmd_t    i2c_cmd,
    output logic         init_done
);

    logic             power_ok;
    logic [IDX_W-1:0] entry_idx;
    sccb_cmd_t        entry_cmd;

    // **********************************************************************
    // settle timer
    // **********************************************************************
    powerup_delay #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) powerup_delay_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .power_ok (power_ok)
    );

    // table walker, talks to the I2C master
    cfg_sequencer cfg_sequencer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .power_ok  (power_ok),
        .i2c_done  (i2c_done),
        .entry_cmd (entry_cmd),
        .entry_idx (entry_idx),
        .i2c_exec  (i2c_exec),
        .i2c_cmd   (i2c_cmd),
        .init_done (init_done)
    );

    // combinational lookup
    cfg_table cfg_table_inst (
        .entry_idx (entry_idx),
        .window    (window),
        .entry_cmd (entry_cmd)
    );

endmodule

// File: tb_ov5640_cfg.sv
`timescale 1ns/1ps

module tb_ov5640_cfg
    import sccb_pkg::*;
    import ov5640_pkg::*;
();

    localparam int WAIT_CYCLES = 40;
    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 4;
    localparam int DRIVE_DLY   = 1;     // input skew after the rising edge
    localparam int TAIL_CYCLES = 100;
    localparam int LCG_MAX_DLY = 8;
    localparam int WINDOW_REGS = 8;

    // stimulus file layout, in 16-bit words
    localparam int GEOM_BASE   = 0;
    localparam int DELAY_BASE  = 4;
    localparam int DELAY_SLOTS = 16;
    localparam int CMD_BASE    = DELAY_BASE + DELAY_SLOTS;
    localparam int STIM_WORDS  = CMD_BASE + 3 * TABLE_LEN;

    logic         clk;
    logic         rst_n;
    cmos_window_t window;
    logic         i2c_done;
    logic         i2c_exec;
    sccb_cmd_t    i2c_cmd;
    logic         init_done;

    logic [15:0]  stim_mem [0:STIM_WORDS-1];
    int           error_count;
    int           timeout_cycles;
    int           exec_count;
    int           window_hits;
    int           delay_idx;
    int unsigned  lcg_state;
    logic [7:0]   window_hi;        // upper byte of the geometry pair in flight
    seq_state_t   seq_state;

    ov5640_cfg_top #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) ov5640_cfg_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .window    (window),
        .i2c_done  (i2c_done),
        .i2c_exec  (i2c_exec),
        .i2c_cmd   (i2c_cmd),
        .init_done (init_done)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // **********************************************************************
    // helpers
    // **********************************************************************
    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_window_reg(input logic [15:0] addr);
        return (addr >= REG_OUT_HSIZE_H) && (addr <= REG_TOTAL_VS_L);
    endfunction

    // geometry value that a high/low register pair carries, keyed by the low register
    function automatic logic [15:0] window_field(input logic [15:0] addr_lo,
                                                 input cmos_window_t w);
        case (addr_lo)
            REG_OUT_HSIZE_L: return 16'(w.h_pixel) & 16'h0fff;   // 12-bit width
            REG_OUT_VSIZE_L: return 16'(w.v_pixel) & 16'h07ff;   // 11-bit height
            REG_TOTAL_HS_L:  return 16'(w.total_h) & 16'h1fff;
            default:         return 16'(w.total_v) & 16'h1fff;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
    endtask

    // file delays first, then pseudo-random ones
    task automatic get_done_delay(output int d);
        if (delay_idx < DELAY_SLOTS) begin
            d = int'(stim_mem[DELAY_BASE + delay_idx]);
            delay_idx++;
        end else begin
            lcg_state = lcg_next(lcg_state);
            d = 1 + int'((lcg_state >> 16) % LCG_MAX_DLY);
        end
        if (d < 1) begin
            d = 1;   // master needs at least one cycle
        end
    endtask

    task automatic check_command(input int n);
        logic [15:0] exp_addr;
        logic [7:0]  exp_data;
        logic        exp_rd;
        exp_addr = stim_mem[CMD_BASE + 3 * n];
        exp_data = stim_mem[CMD_BASE + 3 * n + 1][7:0];
        exp_rd   = stim_mem[CMD_BASE + 3 * n + 2][0];
        check_value($sformatf("i2c_cmd.reg_addr[%0d]", n), i2c_cmd.reg_addr, exp_addr);
        check_value($sformatf("i2c_cmd.reg_data[%0d]", n), i2c_cmd.reg_data, exp_data);
        check_value($sformatf("i2c_cmd.rd[%0d]", n), i2c_cmd.rd, exp_rd);
        check_value($sformatf("i2c_cmd.rd split[%0d]", n), i2c_cmd.rd, n < READ_ENTRIES);
        if (is_window_reg(i2c_cmd.reg_addr)) begin
            if (!i2c_cmd.reg_addr[0]) begin
                window_hi = i2c_cmd.reg_data;   // upper part goes out first
            end else begin
                check_value($sformatf("window pair 0x%0h[%0d]", i2c_cmd.reg_addr, n),
                            {window_hi, i2c_cmd.reg_data},
                            window_field(i2c_cmd.reg_addr, window));
            end
            window_hits++;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RST_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            check_value("i2c_exec in reset", i2c_exec, 0);
            check_value("init_done in reset", init_done, 0);
            check_value("i2c_cmd in reset", i2c_cmd, 0);
        end
        @(posedge clk);
        #DRIVE_DLY rst_n = 1'b1;
    endtask

    // **********************************************************************
    // master model and per-cycle checks
    // **********************************************************************
    task automatic run_sequence();
        int        cyc;
        int        countdown;
        int        tail_count;
        logic      outstanding;
        logic      done_prev;
        logic      init_expect;
        sccb_cmd_t held_cmd;
        cyc         = 0;
        countdown   = 0;
        tail_count  = 0;
        outstanding = 1'b0;
        done_prev   = 1'b0;
        init_expect = 1'b0;
        held_cmd    = '0;
        while (tail_count < TAIL_CYCLES) begin
            @(posedge clk);
            cyc++;
            #DRIVE_DLY;
            if (outstanding && countdown == 1) begin
                i2c_done = 1'b1;
            end else begin
                i2c_done = 1'b0;
                if (outstanding) countdown--;
            end
            @(negedge clk);
            check_value("init_done", init_done, init_expect);
            if (i2c_exec) begin
                if (outstanding) report_error("exec raised while a command was outstanding");
                if (exec_count == 0) begin
                    check_value("first exec cycle", cyc, WAIT_CYCLES + 1);
                end else begin
                    check_value("done before exec", done_prev, 1);
                end
                if (exec_count < TABLE_LEN) begin
                    check_command(exec_count);
                end else begin
                    report_error("exec issued after the last table entry");
                end
                held_cmd    = i2c_cmd;
                outstanding = 1'b1;
                get_done_delay(countdown);
                exec_count++;
            end else begin
                if (exec_count == 0) check_value("i2c_cmd before first exec", i2c_cmd, 0);
                if (outstanding) check_value("i2c_cmd held", i2c_cmd, held_cmd);
                if (done_prev && exec_count < TABLE_LEN) begin
                    report_error("no exec in the cycle after done");
                end
            end
            if (i2c_done) begin
                outstanding = 1'b0;
                if (exec_count == TABLE_LEN) init_expect = 1'b1;   // rises next cycle
            end
            if (init_done && init_expect) tail_count++;
            done_prev = i2c_done;
        end
    endtask

    initial begin
        int max_delay;
        error_count    = 0;
        timeout_cycles = 0;
        exec_count     = 0;
        window_hits    = 0;
        delay_idx      = 0;
        lcg_state      = 32'd63036;
        window_hi      = '0;
        rst_n          = 1'b0;
        i2c_done       = 1'b0;
        window         = '0;
        $readmemh("ov5640_cfg_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[CMD_BASE]) || stim_mem[CMD_BASE] == 16'h0000) begin
            report_error("stimulus file is missing or holds no command list");
        end
        window.h_pixel = stim_mem[GEOM_BASE][12:0];
        window.v_pixel = stim_mem[GEOM_BASE + 1][12:0];
        window.total_h = stim_mem[GEOM_BASE + 2][12:0];
        window.total_v = stim_mem[GEOM_BASE + 3][12:0];
        max_delay = LCG_MAX_DLY;
        for (int i = 0; i < DELAY_SLOTS; i++) begin
            if (int'(stim_mem[DELAY_BASE + i]) > max_delay) begin
                max_delay = int'(stim_mem[DELAY_BASE + i]);
            end
        end
        timeout_cycles = RST_CYCLES + WAIT_CYCLES + 1 + TABLE_LEN * (max_delay + 1)
                         + TAIL_CYCLES + 200;
        apply_reset();
        run_sequence();
        check_value("exec count", exec_count, TABLE_LEN);
        check_value("window entries seen", window_hits, WINDOW_REGS);
        $display("errors: %0d, commands issued: %0d", error_count, exec_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog, limit set once the delays are known
    initial begin
        wait (timeout_cycles > 0);
        #(timeout_cycles * CLK_PERIOD);
        seq_state = ov5640_cfg_top_inst.cfg_sequencer_inst.state;
        $display("TIMEOUT: configuration did not complete, %0d of %0d commands, state %s",
                 exec_count, TABLE_LEN, seq_state.name());
        $display("tests failed");
        $finish;
    end

endmodule

// File: ov5640_cfg_stimulus.txt
// words: h_pixel, v_pixel, total_h, total_v, then 16 done delays in cycles,
// then 45 commands as: reg_addr reg_data rd, in table order
// geometry: 800 x 600, total 4200 x 1000
0320
0258
1068
03e8
// master done delays
0001 0002 0001 0005 0003 0001 000c 0001
0002 0004 0001 0007 0001 0003 0014 0001
// id reads
300a 00 1
300b 00 1
// soft reset, pll clock source
3008 82 0
3008 02 0
3103 02 0
// pad control
3017 ff 0
3018 ff 0
// pll and clocks
3037 13 0
3108 01 0
3035 11 0
3036 3c 0
3000 00 0
3004 ff 0
// rgb565 and isp
4300 61 0
501f 01 0
5000 a7 0
5001 a3 0
// timing and window
3820 46 0
3821 01 0
3814 31 0
3815 31 0
3800 00 0
3801 00 0
3802 00 0
3803 04 0
3804 0a 0
3805 3f 0
3806 07 0
3807 9b 0
// geometry entries
3808 03 0
3809 20 0
380a 02 0
380b 58 0
380c 10 0
380d 68 0
380e 03 0
380f e8 0
3810 00 0
3811 10 0
3813 06 0
// exposure limits
3a02 17 0
3a03 10 0
3a14 17 0
3a15 10 0
// test pattern off
503d 00 0

// File: files.f
sccb_pkg.sv
ov5640_pkg.sv
powerup_delay.sv
cfg_table.sv
cfg_sequencer.sv
ov5640_cfg_top.sv
tb_ov5640_cfg.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_ov5640_cfg
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f files.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL, pass message not found in $LOG"
exit 1
